// File: common/cordic_float_pkg.sv
`default_nettype none

package cordic_float_pkg;

	////////////////////////////////////////////////////
	// Single precision word format.
	////////////////////////////////////////////////////

	localparam int FLOAT_W = 32; // Whole IEEE-754 word.
	localparam int EXP_W   = 8;  // Biased exponent field.
	localparam int MANT_W  = 23; // Fraction field without the hidden bit.

	// Field view of one float word, sign in the top bit.
	typedef struct packed {
		logic              sign;     // 1 means negative.
		logic [EXP_W-1:0]  exponent; // Biased by 127.
		logic [MANT_W-1:0] mantissa; // Stored fraction.
	} float_fields_t;

	// The same 32 bits seen as a raw bus or as its fields.
	// Buses use the raw view and the shifter uses the fields.
	typedef union packed {
		logic [FLOAT_W-1:0] raw;
		float_fields_t      f;
	} float_word_t;

	////////////////////////////////////////////////////
	// Start values for the rotation.
	////////////////////////////////////////////////////

	// X starts at 1/K = 0.607252935, so no gain correction is needed at the end.
	localparam float_word_t X_INIT = float_word_t'(32'h3f1b_74ee);
	localparam float_word_t Y_INIT = float_word_t'(32'h0000_0000); // Y starts at zero.

endpackage

`default_nettype wire

// File: common/cordic_ctrl_pkg.sv
`default_nettype none

package cordic_ctrl_pkg;

	////////////////////////////////////////////////////
	// Sequencer types.
	////////////////////////////////////////////////////

	// Width of the iteration index. It also addresses the arctangent table.
	localparam int ITER_W = 5;

	// Which of the three CORDIC variables is at the adder.
	typedef enum logic [1:0] {
		VAR_X = 2'd0, // X update, uses shifted Y.
		VAR_Y = 2'd1, // Y update, uses shifted X.
		VAR_Z = 2'd2  // Z update, uses the table value.
	} var_sel_t;

	// Controller states, in the order they are normally visited.
	typedef enum logic [3:0] {
		ST_IDLE      = 4'd0,  // Waiting for the host.
		ST_CAPTURE   = 4'd1,  // Inputs are held, counters clear.
		ST_LOAD_WORK = 4'd2,  // Working registers load.
		ST_SHIFT     = 4'd3,  // Shifted values, table value and sign latch.
		ST_ISSUE     = 4'd4,  // Start pulse to the adder.
		ST_WAIT_ADD  = 4'd5,  // Adder is busy.
		ST_STORE     = 4'd6,  // Step to the next variable.
		ST_NEXT_ITER = 4'd7,  // Step to the next iteration or finish.
		ST_SELECT    = 4'd8,  // Pick X or Y.
		ST_SIGN      = 4'd9,  // Quadrant sign correction.
		ST_HOLD      = 4'd10  // Result held for the host.
	} cordic_state_t;

endpackage

`default_nettype wire

// File: common/cordic_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

// Enables and selects from the sequencer to the datapath.
interface cordic_ctrl_if;
	import cordic_ctrl_pkg::*;

	logic              load_input;    // Capture angle, operation and flag.
	logic              load_work;     // Load X, Y and Z working registers.
	logic              sel_feedback;  // 0 picks start values, 1 picks last results.
	logic              load_shift;    // Latch shifted X/Y, table value and Z sign.
	logic              load_result_x; // Store adder result as new X.
	logic              load_result_y; // Store adder result as new Y.
	logic              load_result_z; // Store adder result as new Z.
	logic              load_out;      // Latch the selected function value.
	var_sel_t          var_sel;       // Variable now at the adder.
	logic [ITER_W-1:0] iter;          // Current iteration index.

	// The sequencer side drives everything.
	modport fsm (
		output load_input, load_work, sel_feedback, load_shift,
		output load_result_x, load_result_y, load_result_z, load_out,
		output var_sel, iter
	);

	// The datapath side only listens.
	modport dp (
		input load_input, load_work, sel_feedback, load_shift,
		input load_result_x, load_result_y, load_result_z, load_out,
		input var_sel, iter
	);

endinterface

`default_nettype wire

// File: datapath/cordic_atan_rom.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_atan_rom (
	input  logic [cordic_ctrl_pkg::ITER_W-1:0] iter,       // Iteration index.
	output cordic_float_pkg::float_word_t      atan_value  // atan(2^-iter).
);
	import cordic_float_pkg::*;

	logic [FLOAT_W-1:0] rom_word; // Table output before it is typed.

	// atan(2^-i) in single precision. From i = 12 on the value equals 2^-i.
	always_comb
	begin
		case (iter)
			5'd0:  rom_word = 32'h3f49_0fdb; // pi/4.
			5'd1:  rom_word = 32'h3eed_6338;
			5'd2:  rom_word = 32'h3e7a_dbb0;
			5'd3:  rom_word = 32'h3dfe_add5;
			5'd4:  rom_word = 32'h3d7f_aade;
			5'd5:  rom_word = 32'h3cff_eaae;
			5'd6:  rom_word = 32'h3c7f_faab;
			5'd7:  rom_word = 32'h3bff_feab;
			5'd8:  rom_word = 32'h3b7f_ffab;
			5'd9:  rom_word = 32'h3aff_ffeb;
			5'd10: rom_word = 32'h3a7f_fffb;
			5'd11: rom_word = 32'h39ff_ffff;
			5'd12: rom_word = 32'h3980_0000; // Exact powers of two from here.
			5'd13: rom_word = 32'h3900_0000;
			5'd14: rom_word = 32'h3880_0000;
			5'd15: rom_word = 32'h3800_0000;
			5'd16: rom_word = 32'h3780_0000;
			5'd17: rom_word = 32'h3700_0000;
			5'd18: rom_word = 32'h3680_0000;
			5'd19: rom_word = 32'h3600_0000;
			5'd20: rom_word = 32'h3580_0000;
			5'd21: rom_word = 32'h3500_0000;
			5'd22: rom_word = 32'h3480_0000;
			5'd23: rom_word = 32'h3400_0000;
			5'd24: rom_word = 32'h3380_0000;
			5'd25: rom_word = 32'h3300_0000;
			5'd26: rom_word = 32'h3280_0000;
			5'd27: rom_word = 32'h3200_0000;
			5'd28: rom_word = 32'h3180_0000;
			5'd29: rom_word = 32'h3100_0000;
			5'd30: rom_word = 32'h3080_0000;
			5'd31: rom_word = 32'h3000_0000; // 2^-31.
			default: rom_word = '0;
		endcase
	end

	assign atan_value.raw = rom_word; // Raw view out, fields are decoded downstream.

endmodule

`default_nettype wire

// File: datapath/cordic_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_datapath (
	input  logic                          clk,
	input  logic                          reset,
	cordic_ctrl_if.dp                     ctrl,
	input  cordic_float_pkg::float_word_t data_in,           // Angle in radians.
	input  logic                          operation,         // 1 sine, 0 cosine.
	input  logic [1:0]                    shift_region_flag, // Quadrant sign flag.
	input  cordic_float_pkg::float_word_t atan_value,        // From the table.
	input  cordic_float_pkg::float_word_t result_add_subt,   // From the adder.
	output cordic_float_pkg::float_word_t add_subt_dataA,
	output cordic_float_pkg::float_word_t add_subt_dataB,
	output logic                          op_add_subt,       // 0 add, 1 subtract.
	output cordic_float_pkg::float_word_t data_output
);
	import cordic_float_pkg::*;
	import cordic_ctrl_pkg::*;

	float_word_t in_angle;                 // Captured angle.
	logic        in_op;                    // Captured operation.
	logic [1:0]  in_flag;                  // Captured region flag.
	float_word_t x_work, y_work, z_work;   // Values at the start of an iteration.
	float_word_t x_shift, y_shift;         // X and Y times 2^-i.
	float_word_t atan_reg;                 // Table value for this iteration.
	logic        d_reg;                    // Sign of Z, picks the rotation direction.
	float_word_t x_res, y_res, z_res;      // Values returned by the adder.
	float_word_t out_sel;                  // X or Y before the sign fix.
	logic        out_pending;              // out_sel was loaded last cycle.
	logic        sign_flip;
	float_word_t corrected;

	// Multiplying by 2^-i only lowers the exponent. A value that would underflow
	// is flushed to zero, which also keeps a zero operand at zero.
	function automatic float_word_t scale_down(input float_word_t v,
		input logic [ITER_W-1:0] i);
		float_word_t s;
		s = v;
		if (v.f.exponent > EXP_W'(i))
			s.f.exponent = v.f.exponent - EXP_W'(i);
		else
			s.raw = '0;
		return s;
	endfunction

	//////////////////////////////////////////////////
	// Input and working registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (ctrl.load_input)
		begin
			in_angle <= data_in;
			in_op    <= operation;
			in_flag  <= shift_region_flag;
		end
		// First pass takes the start values, later passes take the adder results.
		if (ctrl.load_work)
		begin
			x_work <= ctrl.sel_feedback ? x_res : X_INIT;
			y_work <= ctrl.sel_feedback ? y_res : Y_INIT;
			z_work <= ctrl.sel_feedback ? z_res : in_angle;
		end
		if (ctrl.load_shift)
		begin
			x_shift  <= scale_down(x_work, ctrl.iter);
			y_shift  <= scale_down(y_work, ctrl.iter);
			atan_reg <= atan_value;
			d_reg    <= z_work.f.sign; // Rotation mode steers by Z only.
		end
	end

	// The three results land in separate registers, so the working values stay intact.
	always_ff @(posedge clk)
	begin
		if (ctrl.load_result_x)
			x_res <= result_add_subt;
		if (ctrl.load_result_y)
			y_res <= result_add_subt;
		if (ctrl.load_result_z)
			z_res <= result_add_subt;
	end

	//////////////////////////////////////////////////
	// Adder operands
	//////////////////////////////////////////////////

	// x - d*y', y + d*x', z - d*atan, with d_reg = 0 meaning d = +1.
	always_comb
	begin
		case (ctrl.var_sel)
			VAR_X:
			begin
				add_subt_dataA = x_work;
				add_subt_dataB = y_shift;
				op_add_subt    = ~d_reg;
			end
			VAR_Y:
			begin
				add_subt_dataA = y_work;
				add_subt_dataB = x_shift;
				op_add_subt    = d_reg;
			end
			default:
			begin
				add_subt_dataA = z_work; // The Z update.
				add_subt_dataB = atan_reg;
				op_add_subt    = ~d_reg;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Output select and sign fix
	//////////////////////////////////////////////////

	// Bit 0 flips both functions, bit 1 flips cosine only, so both cancel for cosine.
	assign sign_flip = in_flag[0] ^ (in_flag[1] & ~in_op);

	always_comb
	begin
		corrected = out_sel;
		corrected.f.sign = out_sel.f.sign ^ sign_flip;
	end

	always_ff @(posedge clk)
	begin
		if (ctrl.load_out)
			out_sel <= in_op ? y_res : x_res; // Y is sine and X is cosine.
	end

	// The corrected word goes out one cycle after the select.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_pending <= 1'b0;
			data_output <= '0;
		end
		else
		begin
			out_pending <= ctrl.load_out;
			if (out_pending)
				data_output <= corrected;
		end
	end

endmodule

`default_nettype wire

// File: control/cordic_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_fsm #(
	parameter int N_ITER = 24 // Iterations per operation, 1 to 32.
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       beg_fsm_cordic, // Host start pulse.
	input  logic       ack_cordic,     // Host has taken the result.
	input  logic       ready_add_subt, // Adder result is valid.
	output logic       ready_cordic,
	output logic       beg_add_subt,
	output logic       ack_add_subt,
	cordic_ctrl_if.fsm ctrl
);
	import cordic_ctrl_pkg::*;

	cordic_state_t     state, state_next;
	logic [ITER_W-1:0] iter_cnt; // Counts 0 up to N_ITER-1.
	var_sel_t          var_cnt;  // Walks X, Y, Z within an iteration.
	logic              last_iter;
	logic              add_done; // Adder result seen this cycle.

	assign last_iter = (iter_cnt == ITER_W'(N_ITER - 1));
	assign add_done  = (state == ST_WAIT_ADD) && ready_add_subt;

	//////////////////////////////////////////////////
	// State and counters
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= ST_IDLE;
		else
			state <= state_next;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			iter_cnt <= '0;
			var_cnt  <= VAR_X;
		end
		else if (state == ST_CAPTURE)
		begin
			iter_cnt <= '0; // Fresh start for every operation.
			var_cnt  <= VAR_X;
		end
		else if (state == ST_STORE)
		begin
			case (var_cnt)
				VAR_X:   var_cnt <= VAR_Y;
				VAR_Y:   var_cnt <= VAR_Z;
				default: var_cnt <= VAR_X; // Wraps for the next iteration.
			endcase
		end
		else if (state == ST_NEXT_ITER && !last_iter)
			iter_cnt <= iter_cnt + 1'b1;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			ST_IDLE:      if (beg_fsm_cordic) state_next = ST_CAPTURE;
			ST_CAPTURE:   state_next = ST_LOAD_WORK;
			ST_LOAD_WORK: state_next = ST_SHIFT;
			ST_SHIFT:     state_next = ST_ISSUE;
			ST_ISSUE:     state_next = ST_WAIT_ADD;
			ST_WAIT_ADD:  if (ready_add_subt) state_next = ST_STORE; // No timeout.
			ST_STORE:     state_next = (var_cnt == VAR_Z) ? ST_NEXT_ITER : ST_ISSUE;
			ST_NEXT_ITER: state_next = last_iter ? ST_SELECT : ST_LOAD_WORK;
			ST_SELECT:    state_next = ST_SIGN;
			ST_SIGN:      state_next = ST_HOLD;
			ST_HOLD:      if (ack_cordic) state_next = ST_IDLE;
			default:      state_next = ST_IDLE;
		endcase
	end

	//////////////////////////////////////////////////
	// Handshakes and datapath controls
	//////////////////////////////////////////////////

	assign ready_cordic = (state == ST_HOLD);
	assign beg_add_subt = (state == ST_ISSUE); // One cycle, ISSUE never repeats.
	assign ack_add_subt = add_done;

	// Inputs are taken in the start cycle itself, and only from idle.
	assign ctrl.load_input    = (state == ST_IDLE) && beg_fsm_cordic;
	assign ctrl.load_work     = (state == ST_LOAD_WORK);
	assign ctrl.sel_feedback  = (iter_cnt != '0);
	assign ctrl.load_shift    = (state == ST_SHIFT);
	assign ctrl.load_result_x = add_done && (var_cnt == VAR_X);
	assign ctrl.load_result_y = add_done && (var_cnt == VAR_Y);
	assign ctrl.load_result_z = add_done && (var_cnt == VAR_Z);
	assign ctrl.load_out      = (state == ST_SELECT);
	assign ctrl.var_sel       = var_cnt; // Held through issue and wait.
	assign ctrl.iter          = iter_cnt;

endmodule

`default_nettype wire

// File: verilog/cordic_coprocessor.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_coprocessor #(
	parameter int N_ITER = 24 // Passed to the sequencer.
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        beg_fsm_cordic,    // Start, one cycle.
	input  logic        ack_cordic,        // Result taken.
	input  logic        operation,         // 1 sine, 0 cosine.
	input  logic        ready_add_subt,    // Adder done.
	input  logic [31:0] data_in,           // Angle, single precision.
	input  logic [31:0] result_add_subt,   // Adder sum or difference.
	input  logic [1:0]  shift_region_flag, // Quadrant sign flag.
	output logic        ready_cordic,      // data_output is valid.
	output logic        beg_add_subt,      // Adder start.
	output logic        ack_add_subt,      // Adder result taken.
	output logic        op_add_subt,       // 0 add, 1 subtract.
	output logic [31:0] add_subt_dataA,
	output logic [31:0] add_subt_dataB,
	output logic [31:0] data_output        // Sine or cosine.
);
	import cordic_float_pkg::*;

	cordic_ctrl_if ctrl_bus ();

	float_word_t data_in_w, result_w, atan_w; // Typed views of the inputs.
	float_word_t data_a_w, data_b_w, data_out_w;

	// Plain buses are typed here and nowhere else.
	assign data_in_w.raw  = data_in;
	assign result_w.raw   = result_add_subt;
	assign add_subt_dataA = data_a_w.raw;
	assign add_subt_dataB = data_b_w.raw;
	assign data_output    = data_out_w.raw;

	cordic_fsm #(.N_ITER(N_ITER)) u_fsm (
		.clk(clk), .reset(reset),
		.beg_fsm_cordic(beg_fsm_cordic), .ack_cordic(ack_cordic),
		.ready_add_subt(ready_add_subt), .ready_cordic(ready_cordic),
		.beg_add_subt(beg_add_subt), .ack_add_subt(ack_add_subt),
		.ctrl(ctrl_bus.fsm)
	);

	cordic_atan_rom u_rom (.iter(ctrl_bus.iter), .atan_value(atan_w));

	cordic_datapath u_datapath (
		.clk(clk), .reset(reset), .ctrl(ctrl_bus.dp),
		.data_in(data_in_w), .operation(operation),
		.shift_region_flag(shift_region_flag), .atan_value(atan_w),
		.result_add_subt(result_w), .add_subt_dataA(data_a_w),
		.add_subt_dataB(data_b_w), .op_add_subt(op_add_subt),
		.data_output(data_out_w)
	);

endmodule

`default_nettype wire

// File: bench/cordic_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// Handshake rules of the coprocessor, checked at its own ports.
module cordic_asserts (
	input logic        clk,
	input logic        reset,
	input logic        ready_add_subt,
	input logic        ack_add_subt,
	input logic        beg_add_subt,
	input logic        ready_cordic,
	input logic [31:0] data_output
);

	// The adder is only acknowledged while it offers a result.
	a_ack_with_ready: assert property (@(posedge clk) disable iff (reset)
		ack_add_subt |-> ready_add_subt)
		else $error("ack_add_subt was raised without ready_add_subt.");

	a_beg_pulse: assert property (@(posedge clk) disable iff (reset)
		beg_add_subt |=> !beg_add_subt) // Start lasts one cycle.
		else $error("beg_add_subt stayed high for more than one cycle.");

	// While ready stays up the host sees one fixed value.
	a_output_held: assert property (@(posedge clk) disable iff (reset)
		ready_cordic |=> !ready_cordic || $stable(data_output))
		else $error("data_output changed while ready_cordic was high.");

endmodule

bind cordic_coprocessor cordic_asserts u_asserts (
	.clk(clk), .reset(reset), .ready_add_subt(ready_add_subt),
	.ack_add_subt(ack_add_subt), .beg_add_subt(beg_add_subt),
	.ready_cordic(ready_cordic), .data_output(data_output)
);

`default_nettype wire

// File: bench/cordic_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_tb;

	localparam int  TIMEOUT = 5000; // Cycles allowed for one wait.
	localparam real TOL     = 1e-4; // Absolute error allowed on a result.

	logic        clk = 1'b0;
	logic        reset, beg_fsm_cordic, ack_cordic, operation;
	logic        ready_add_subt = 1'b0;         // Driven by the adder model below.
	logic [31:0] data_in;
	logic [31:0] result_add_subt = 32'd0;
	logic [1:0]  shift_region_flag;
	logic        ready_cordic, beg_add_subt, ack_add_subt, op_add_subt;
	logic [31:0] add_subt_dataA, add_subt_dataB, data_output;
	logic        stall_mode;                    // 1 makes every adder call take 20 cycles.
	logic        adder_busy = 1'b0;
	int          delay_left = 0;
	logic [31:0] issued_a = 32'd0;              // Operands seen with the start pulse.
	logic [31:0] issued_b = 32'd0;
	logic        issued_op = 1'b0;
	real         test_angles [5] = '{0.0, 0.5, 1.0, -1.2, 1.5};

	cordic_coprocessor #(.N_ITER(24)) uut (.*);

	always #4 clk = ~clk; // 8 ns period.

	// Single precision bits to a real. Denormals count as zero.
	function automatic real float_to_real(input logic [31:0] w);
		logic [63:0] d;
		if (w[30:23] == 8'd0)
			return 0.0;
		d = {w[31], 11'(w[30:23]) + 11'd896, w[22:0], 29'd0}; // Rebias 127 to 1023.
		return $bitstoreal(d);
	endfunction

	// A real to single precision bits, rounding the dropped half up.
	function automatic logic [31:0] real_to_float(input real r);
		logic [63:0] d;
		logic [24:0] m;
		int          e;
		d = $realtobits(r);
		e = int'(d[62:52]) - 896;
		if (d[62:52] == 11'd0 || e <= 0)
			return 32'd0; // Too small for a normal single.
		m = {2'b01, d[51:29]} + 25'(d[28]);
		if (m[24])
		begin
			e = e + 1; // Rounding carried into the exponent.
			m = m >> 1;
		end
		return {d[63], e[7:0], m[22:0]};
	endfunction

	function automatic logic [31:0] add_or_sub(input logic [31:0] a, input logic [31:0] b,
		input logic subtract);
		if (subtract)
			return real_to_float(float_to_real(a) - float_to_real(b));
		return real_to_float(float_to_real(a) + float_to_real(b));
	endfunction

	//////////////////////////////////////////////////
	// Adder model
	//////////////////////////////////////////////////

	// Answers each start pulse after a delay and holds the sum until it is taken.
	always @(posedge clk)
	begin
		if (reset)
		begin
			ready_add_subt <= 1'b0;
			adder_busy     <= 1'b0;
		end
		else if (ready_add_subt)
		begin
			verify_operands_held(); // Still owed until the result is taken.
			if (ack_add_subt)
				ready_add_subt <= 1'b0; // Result taken.
		end
		else if (adder_busy)
		begin
			verify_operands_held();
			if (delay_left == 0)
			begin
				result_add_subt <= add_or_sub(add_subt_dataA, add_subt_dataB, op_add_subt);
				ready_add_subt  <= 1'b1;
				adder_busy      <= 1'b0;
			end
			else
				delay_left <= delay_left - 1;
		end
		else if (beg_add_subt)
		begin
			adder_busy <= 1'b1;
			delay_left <= stall_mode ? 20 : int'($urandom % 6); // Operands stay put meanwhile.
			issued_a   <= add_subt_dataA;
			issued_b   <= add_subt_dataB;
			issued_op  <= op_add_subt;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic report_failure();
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	// A one-bit output against the level it must have.
	task automatic expect_level(input string name, input logic got, input logic expected);
		assert (got === expected)
		else
		begin
			$display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, expected);
			report_failure();
		end
	endtask

	// The adder operands may not move between the start pulse and the taken result.
	task automatic verify_operands_held();
		assert (add_subt_dataA === issued_a)
		else
		begin
			$display("[FAIL] %0t add_subt_dataA: got %h, expected %h", $time,
				add_subt_dataA, issued_a);
			report_failure();
		end
		assert (add_subt_dataB === issued_b)
		else
		begin
			$display("[FAIL] %0t add_subt_dataB: got %h, expected %h", $time,
				add_subt_dataB, issued_b);
			report_failure();
		end
		expect_level("op_add_subt", op_add_subt, issued_op);
	endtask

	// Samples at the falling edge, where the outputs are settled.
	task automatic wait_ready(input logic level);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (ready_cordic !== level)
		begin
			cycles = cycles + 1;
			assert (cycles < TIMEOUT)
			else
			begin
				$display("Timed out waiting for ready_cordic to become %0b.", level);
				report_failure();
			end
			@(negedge clk);
		end
	endtask

	task automatic start_op(input real angle, input logic op, input logic [1:0] flag);
		@(posedge clk);
		beg_fsm_cordic    <= 1'b1;
		data_in           <= real_to_float(angle);
		operation         <= op;
		shift_region_flag <= flag;
		@(posedge clk);
		beg_fsm_cordic <= 1'b0; // Start is a single cycle.
		wait_ready(1'b1);
	endtask

	task automatic release_result();
		@(posedge clk);
		ack_cordic <= 1'b1;
		@(posedge clk);
		ack_cordic <= 1'b0;
		wait_ready(1'b0);
	endtask

	// Expected value from the math library, then the quadrant sign rule.
	task automatic check_result(input real angle, input logic op, input logic [1:0] flag);
		real expected;
		real got;
		expected = op ? $sin(angle) : $cos(angle);
		if (flag[0])
			expected = -expected; // Bit 0 negates sine and cosine.
		if (flag[1] && !op)
			expected = -expected; // Bit 1 negates cosine only.
		got = float_to_real(data_output);
		assert ((got - expected) < TOL && (expected - got) < TOL)
		else
		begin
			$display("[FAIL] %0t data_output: got %f, expected %f", $time, got, expected);
			report_failure();
		end
	endtask

	task automatic compute(input real angle, input logic op, input logic [1:0] flag);
		start_op(angle, op, flag);
		check_result(angle, op, flag);
		release_result();
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_reset();
		@(negedge clk);
		expect_level("ready_cordic", ready_cordic, 1'b0);
		expect_level("beg_add_subt", beg_add_subt, 1'b0);
		expect_level("ack_add_subt", ack_add_subt, 1'b0);
		assert (data_output === 32'd0)
		else
		begin
			$display("[FAIL] %0t data_output: got %h, expected %h", $time, data_output, 32'd0);
			report_failure();
		end
	endtask

	task automatic test_cosine();
		foreach (test_angles[i])
			compute(test_angles[i], 1'b0, 2'b00);
	endtask

	task automatic test_sine();
		real angle;
		foreach (test_angles[i])
			compute(test_angles[i], 1'b1, 2'b00);
		repeat (10)
		begin
			angle = real'($urandom % 30001) / 10000.0 - 1.5; // Uniform in +-1.5.
			compute(angle, 1'b1, 2'b00);
		end
	endtask

	task automatic test_flags();
		for (int s = 0; s < 2; s++)
			for (int f = 1; f < 4; f++)
				compute(0.8, 1'(s), 2'(f));
	endtask

	// The result must sit still while the host holds back its acknowledge.
	task automatic test_hold();
		logic [31:0] held;
		start_op(0.3, 1'b1, 2'b00);
		held = data_output;
		for (int i = 0; i < 20; i++)
		begin
			@(posedge clk);
			beg_fsm_cordic <= (i == 5); // A second start, which must be ignored.
			data_in        <= real_to_float(1.0);
			@(negedge clk);
			expect_level("ready_cordic", ready_cordic, 1'b1);
			assert (data_output === held)
			else
			begin
				$display("[FAIL] %0t data_output: got %h, expected %h", $time, data_output, held);
				report_failure();
			end
		end
		release_result();
		// A start pulse taken during the hold would show up here as a new operation.
		repeat (5)
		begin
			@(negedge clk);
			expect_level("beg_add_subt", beg_add_subt, 1'b0);
			expect_level("ready_cordic", ready_cordic, 1'b0);
		end
	endtask

	task automatic test_stall();
		stall_mode = 1'b1;
		compute(0.7, 1'b0, 2'b00);
		stall_mode = 1'b0;
	endtask

	initial
	begin
		void'($urandom(32'h3456_8bc1)); // One seed for the whole run.
		reset             = 1'b1;
		beg_fsm_cordic    = 1'b0;
		ack_cordic        = 1'b0;
		operation         = 1'b0;
		data_in           = 32'd0;
		shift_region_flag = 2'b00;
		stall_mode        = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		test_reset();
		test_cosine();
		test_sine();
		test_flags();
		test_hold();
		test_stall();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
common/cordic_float_pkg.sv
common/cordic_ctrl_pkg.sv
common/cordic_ctrl_if.sv
datapath/cordic_atan_rom.sv
datapath/cordic_datapath.sv
control/cordic_fsm.sv
verilog/cordic_coprocessor.sv
bench/cordic_asserts.sv
bench/cordic_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the CORDIC testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

log_file=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module cordic_tb -f project.f -o cordic_sim; then
	echo "Verilator build failed."
	exit 1
fi

./obj_dir/cordic_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status."
	exit 1
fi

if grep -q "CHECKS FAILED" "$log_file"; then
	echo "Failure reported in $log_file."
	exit 1
fi

echo "Simulation finished without failures."
exit 0
